// ==== all.f ====
+incdir+hdl
hdl/hamming_pkg.sv
hdl/hamming_encoder.sv
hdl/ecc_block_store.sv
hdl/hamming_block_corrector.sv
hdl/ecc_wb_frontend.sv
hdl/ecc_memory_top.sv
testbench/tb_ecc_memory.sv

// ==== hdl/ecc_block_store.sv ====
/*
  Block memory with one write and one read port. Read data follows the index
  by one cycle. Contents are undefined until written; there is no reset.
*/

`default_nettype none

`include "hamming_params.svh"

module ecc_block_store #(
  parameter int DEPTH = `ECC_STORE_DEPTH
) (
  input  logic                        clk,
  input  logic                        we,
  input  logic [`ECC_ADDR_WIDTH-1:0]  index,
  input  hamming_pkg::hamming_block_t wr_block,
  output hamming_pkg::hamming_block_t rd_block
);

  // Block array
  hamming_pkg::hamming_block_t mem [DEPTH];

  // Read index, captured every cycle
  logic [`ECC_ADDR_WIDTH-1:0] index_q;

  // Write at the edge when enabled
  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wr_block;
    end
  end

  // Register the index so read data lands one cycle later
  // A write and read of the same entry return the new block
  always_ff @(posedge clk) begin
    index_q <= index;
  end

  assign rd_block = mem[index_q];

  // Writes must stay inside the array
  property p_write_in_range;
    @(posedge clk) we |-> (int'(index) < DEPTH);
  endproperty

  a_write_in_range : assert property (p_write_in_range)
    else $error("block store write index %0d beyond depth %0d", index, DEPTH);

endmodule

`default_nettype wire

// ==== hdl/ecc_memory_top.sv ====
/*
  Single-error-correcting memory behind a Wishbone classic slave port.
  Sixteen 26-bit words; no double-error detection, no scrubbing.
*/

`default_nettype none

`include "hamming_params.svh"

module ecc_memory_top (
  input  logic                 clk,
  input  logic                 rst,
  input  hamming_pkg::wb_req_t wb_req,
  output hamming_pkg::wb_rsp_t wb_rsp
);

  hamming_pkg::hamming_data_t   enc_data;
  hamming_pkg::hamming_block_t  enc_block;
  logic                         store_we;
  logic [`ECC_ADDR_WIDTH-1:0]   store_index;
  hamming_pkg::hamming_block_t  store_wr_block;
  hamming_pkg::hamming_block_t  store_rd_block;
  logic                         corr_error;
  hamming_pkg::hamming_data_t   corr_data;

  // Bus side, sequences the other three blocks
  ecc_wb_frontend i_ecc_wb_frontend (
    .clk           (clk),
    .rst           (rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .enc_data      (enc_data),
    .enc_block     (enc_block),
    .store_we      (store_we),
    .store_index   (store_index),
    .store_wr_block(store_wr_block),
    .store_rd_block(store_rd_block),
    .corr_error    (corr_error),
    .corr_data     (corr_data)
  );

  // Producer
  hamming_encoder #(
    .BLOCK_WIDTH(`HAMMING_BLOCK_WIDTH)
  ) i_hamming_encoder (
    .data (enc_data),
    .block(enc_block)
  );

  // Buffer
  ecc_block_store #(
    .DEPTH(`ECC_STORE_DEPTH)
  ) i_ecc_block_store (
    .clk     (clk),
    .we      (store_we),
    .index   (store_index),
    .wr_block(store_wr_block),
    .rd_block(store_rd_block)
  );

  // Consumer
  hamming_block_corrector i_hamming_block_corrector (
    .block         (store_rd_block),
    .error         (corr_error),
    .corrected_data(corr_data)
  );

endmodule

`default_nettype wire

// ==== hdl/ecc_wb_frontend.sv ====
/*
  Wishbone classic slave, one transfer at a time, no stalls. Writes and STATUS reads
  ack after one cycle, DATA and RAW reads after two. Byte selects are ignored.
*/

`default_nettype none

`include "hamming_params.svh"

module ecc_wb_frontend (
  input  logic                        clk,
  input  logic                        rst,
  input  hamming_pkg::wb_req_t        wb_req,
  output hamming_pkg::wb_rsp_t        wb_rsp,
  output hamming_pkg::hamming_data_t  enc_data,
  input  hamming_pkg::hamming_block_t enc_block,
  output logic                        store_we,
  output logic [`ECC_ADDR_WIDTH-1:0]  store_index,
  output hamming_pkg::hamming_block_t store_wr_block,
  input  hamming_pkg::hamming_block_t store_rd_block,
  input  logic                        corr_error,
  input  hamming_pkg::hamming_data_t  corr_data
);

  typedef enum logic [1:0] {
    IDLE,
    READ_WAIT,
    ACK
  } state_t;

  state_t                         state_q;
  state_t                         state_d;
  logic [1:0]                     region;
  logic                           start;
  logic                           region_mem;
  logic [`ECC_WB_DATA_WIDTH-1:0]  read_word;
  logic [`ECC_WB_DATA_WIDTH-1:0]  rsp_dat_q;
  logic [`ECC_COUNT_WIDTH-1:0]    err_count_q;

  // Region comes from word address bits 5 and 4
  assign region     = wb_req.adr[5:4];
  assign region_mem = (region == `ECC_REGION_DATA) || (region == `ECC_REGION_RAW);

  // New request, only taken when idle
  assign start = (state_q == IDLE) && wb_req.cyc && wb_req.stb;

  // Store write port, one cycle per write request
  assign store_we       = start && wb_req.we && region_mem;
  assign store_index    = wb_req.adr[`ECC_ADDR_WIDTH-1:0];
  assign enc_data       = wb_req.dat[`HAMMING_DATA_WIDTH-1:0];
  // RAW writes bypass the encoder to allow error injection
  assign store_wr_block = (region == `ECC_REGION_RAW) ?
                          wb_req.dat[`HAMMING_BLOCK_WIDTH-1:0] : enc_block;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          // Memory reads wait one cycle for the store
          state_d = (!wb_req.we && region_mem) ? READ_WAIT : ACK;
        end
      end
      READ_WAIT: state_d = ACK;
      ACK:       state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Format read data per region, unused bits zero
  always_comb begin
    read_word = '0;
    case (region)
      `ECC_REGION_DATA: begin
        read_word[`HAMMING_DATA_WIDTH-1:0] = corr_data;
        read_word[`ECC_FLAG_BIT]           = corr_error;
      end
      `ECC_REGION_RAW: begin
        read_word[`HAMMING_BLOCK_WIDTH-1:0] = store_rd_block;
      end
      `ECC_REGION_STATUS: begin
        read_word[`ECC_COUNT_WIDTH-1:0] = err_count_q;
      end
      default: begin
        read_word = '0;
      end
    endcase
  end

  // Response register, memory reads load once store data is valid
  always_ff @(posedge clk) begin
    if ((state_q == READ_WAIT) || (start && !wb_req.we && !region_mem)) begin
      rsp_dat_q <= read_word;
    end
  end

  // Corrected-read counter, saturating, cleared by a STATUS write
  always_ff @(posedge clk) begin
    if (rst) begin
      err_count_q <= '0;
    end else if (start && wb_req.we && (region == `ECC_REGION_STATUS)) begin
      err_count_q <= '0;
    end else if ((state_q == READ_WAIT) && (region == `ECC_REGION_DATA) && corr_error &&
                 (err_count_q != '1)) begin
      err_count_q <= err_count_q + 1'b1;
    end
  end

  assign wb_rsp.ack = (state_q == ACK);
  assign wb_rsp.dat = rsp_dat_q;

  // Ack is a single-cycle pulse
  a_ack_pulse : assert property (@(posedge clk) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack held high for two cycles");

  // Ack only answers an active request
  a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
    $rose(wb_rsp.ack) |-> (wb_req.cyc && wb_req.stb))
    else $error("ack raised outside an active bus cycle");

endmodule

`default_nettype wire

// ==== hdl/hamming_block_corrector.sv ====
/*
  Combinational single-error corrector. Any nonzero syndrome is treated as one
  flipped bit; a double error is therefore miscorrected and still flagged.
*/

`default_nettype none

`include "hamming_params.svh"

module hamming_block_corrector (
  input  hamming_pkg::hamming_block_t block,
  output logic                        error,
  output hamming_pkg::hamming_data_t  corrected_data
);

  hamming_pkg::hamming_data_t        received_data;
  hamming_pkg::hamming_block_t       expected_block;
  hamming_pkg::hamming_block_t       error_mask;
  hamming_pkg::hamming_block_t       corrected_block;
  hamming_pkg::hamming_block_t       check_block;
  logic [`HAMMING_PARITY_WIDTH-1:0]  syndrome;

  // Data as received, possibly with a bad bit
  assign received_data = hamming_pkg::extract_data(block);

  // Re-encode the received data for the expected parity
  hamming_encoder #(
    .BLOCK_WIDTH(`HAMMING_BLOCK_WIDTH)
  ) i_encoder (
    .data (received_data),
    .block(expected_block)
  );

  // Syndrome is received parity XOR expected parity
  always_comb begin
    for (int k = 0; k < `HAMMING_PARITY_WIDTH; k++) begin
      syndrome[k] = block[(1 << k) - 1] ^ expected_block[(1 << k) - 1];
    end
  end

  assign error = |syndrome;

  // Syndrome value is the 1-based position of the bad bit
  // With a 2**n - 1 block every nonzero value is a valid position
  always_comb begin
    error_mask = '0;
    if (syndrome != '0) begin
      error_mask[int'(syndrome) - 1] = 1'b1;
    end
  end

  assign corrected_block = block ^ error_mask;
  assign corrected_data  = hamming_pkg::extract_data(corrected_block);

  // Re-encode the corrected data, used only by the check below
  hamming_encoder #(
    .BLOCK_WIDTH(`HAMMING_BLOCK_WIDTH)
  ) i_check_encoder (
    .data (corrected_data),
    .block(check_block)
  );

  // Corrected block must be a valid codeword; skipped while the store holds X
  always_comb begin
    if (!$isunknown(block)) begin
      a_codeword : assert final (check_block == corrected_block)
        else $error("corrected block %h is not a codeword", corrected_block);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hamming_encoder.sv ====
/*
  Combinational Hamming encoder, zero latency. BLOCK_WIDTH must match the package
  block type, so changing the size means changing the params header as well.
*/

`default_nettype none

`include "hamming_params.svh"

module hamming_encoder #(
  parameter int BLOCK_WIDTH = `HAMMING_BLOCK_WIDTH
) (
  input  hamming_pkg::hamming_data_t  data,
  output hamming_pkg::hamming_block_t block
);

  // One parity bit per bit of the 1-based position index
  localparam int PARITY_WIDTH = $clog2(BLOCK_WIDTH + 1);

  hamming_pkg::hamming_block_t placed;
  logic [PARITY_WIDTH-1:0]     parity;

  // Size must line up with the shared block type
  if (BLOCK_WIDTH != $bits(hamming_pkg::hamming_block_t)) begin : g_width_check
    $error("hamming_encoder BLOCK_WIDTH does not match hamming_block_t");
  end

  if (PARITY_WIDTH != `HAMMING_PARITY_WIDTH) begin : g_parity_check
    $error("hamming_encoder parity width does not match the params header");
  end

  // Data bits go to the non-parity positions
  assign placed = hamming_pkg::place_data(data);

  // Parity k covers every position whose index has bit k set
  // Parity slots in placed are zero so they drop out of the XOR
  always_comb begin
    parity = '0;
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      for (int p = 1; p <= BLOCK_WIDTH; p++) begin
        if (((p >> k) & 1) == 1) begin
          parity[k] = parity[k] ^ placed[p-1];
        end
      end
    end
  end

  // Drop parity bits into the power-of-two positions
  always_comb begin
    block = placed;
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      block[(1 << k) - 1] = parity[k];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hamming_params.svh ====
/*
  Widths and address map for the 31/26 Hamming memory. The block width must be 2**n - 1
  and the parity width n. No overall parity bit exists, so double errors miscorrect.
*/

`ifndef HAMMING_PARAMS_SVH
`define HAMMING_PARAMS_SVH

// Hamming block geometry
`define HAMMING_BLOCK_WIDTH 31
`define HAMMING_DATA_WIDTH 26
`define HAMMING_PARITY_WIDTH 5

// Block store size
`define ECC_STORE_DEPTH 16
`define ECC_ADDR_WIDTH 4

// Wishbone port widths, word addressed
`define ECC_WB_ADR_WIDTH 6
`define ECC_WB_DATA_WIDTH 32

// Region codes from address bits 5 and 4
`define ECC_REGION_DATA 2'd0
`define ECC_REGION_RAW 2'd1
`define ECC_REGION_STATUS 2'd2

// Error flag position in a data read, and corrected-read counter width
`define ECC_FLAG_BIT 31
`define ECC_COUNT_WIDTH 16

`endif

// ==== hdl/hamming_pkg.sv ====
/*
  Bus structs and Hamming block types. Bit p-1 of a block holds position p (1-based);
  power-of-two positions hold parity, the others hold data in ascending order.
*/

`default_nettype none

`include "hamming_params.svh"

package hamming_pkg;

  typedef logic [`HAMMING_BLOCK_WIDTH-1:0] hamming_block_t;
  typedef logic [`HAMMING_DATA_WIDTH-1:0] hamming_data_t;

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [`ECC_WB_ADR_WIDTH-1:0]  adr;
    logic [`ECC_WB_DATA_WIDTH-1:0] dat;
  } wb_req_t;

  // Wishbone classic response, slave to master
  typedef struct packed {
    logic                          ack;
    logic [`ECC_WB_DATA_WIDTH-1:0] dat;
  } wb_rsp_t;

  // Gather data bits from the non-power-of-two positions
  function automatic hamming_data_t extract_data(input hamming_block_t block);
    hamming_data_t data;
    int            d;
    data = '0;
    d    = 0;
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      if ((p & (p - 1)) != 0) begin
        data[d] = block[p-1];
        d++;
      end
    end
    return data;
  endfunction

  // Scatter data bits into the block, parity positions left at zero
  function automatic hamming_block_t place_data(input hamming_data_t data);
    hamming_block_t block;
    int             d;
    block = '0;
    d     = 0;
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      if ((p & (p - 1)) != 0) begin
        block[p-1] = data[d];
        d++;
      end
    end
    return block;
  endfunction

endpackage

`default_nettype wire

// ==== testbench/tb_ecc_memory.sv ====
/*
  Self-checking testbench for the ECC memory. It stops at the first mismatch.
  The reference model takes the syndrome as the XOR of the positions of all set bits.
*/

`default_nettype none

`include "hamming_params.svh"

module tb_ecc_memory;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES     = 3;
  localparam int CYCLES_PER_ENTRY = 20;
  localparam int COUNT_MAX        = (1 << `ECC_COUNT_WIDTH) - 1;

  typedef enum {OP_WRITE, OP_READ} op_t;

  // One table row
  // Expected is ignored when use_model is set
  typedef struct {
    string       name;
    op_t         op;
    logic [5:0]  adr;
    logic [31:0] wdata;
    logic [31:0] expected;
    bit          use_model;
  } entry_t;

  logic                        clk = 1'b0;
  logic                        rst;
  hamming_pkg::wb_req_t        wb_req;
  hamming_pkg::wb_rsp_t        wb_rsp;
  entry_t                      test_table[$];
  bit                          table_ready = 1'b0;
  int                          fail_count  = 0;
  // Shadow of the block store and of the error counter
  hamming_pkg::hamming_block_t shadow_mem [`ECC_STORE_DEPTH];
  int                          model_count = 0;

  ecc_memory_top i_ecc_memory_top (
    .clk   (clk),
    .rst   (rst),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
  );

  always #5 clk = ~clk;

  // XOR of the 1-based positions of all set bits
  // Zero for a codeword
  function automatic logic [`HAMMING_PARITY_WIDTH-1:0] model_syndrome(
    input hamming_pkg::hamming_block_t blk
  );
    logic [`HAMMING_PARITY_WIDTH-1:0] s;
    s = '0;
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      if (blk[p-1]) begin
        s = s ^ p[`HAMMING_PARITY_WIDTH-1:0];
      end
    end
    return s;
  endfunction

  // Data into non-power-of-two positions, then parity cancels the syndrome
  function automatic hamming_pkg::hamming_block_t model_encode(
    input hamming_pkg::hamming_data_t d
  );
    hamming_pkg::hamming_block_t      blk;
    logic [`HAMMING_PARITY_WIDTH-1:0] s;
    int                               n;
    blk = '0;
    n   = 0;
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      if ($countones(p) != 1) begin
        blk[p-1] = d[n];
        n++;
      end
    end
    s = model_syndrome(blk);
    for (int k = 0; k < `HAMMING_PARITY_WIDTH; k++) begin
      blk[(1 << k) - 1] = s[k];
    end
    return blk;
  endfunction

  function automatic hamming_pkg::hamming_data_t model_extract(
    input hamming_pkg::hamming_block_t blk
  );
    hamming_pkg::hamming_data_t d;
    int                         n;
    d = '0;
    n = 0;
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      if ($countones(p) != 1) begin
        d[n] = blk[p-1];
        n++;
      end
    end
    return d;
  endfunction

  // Bus word of a DATA read
  function automatic logic [31:0] data_word(input logic flag, input hamming_pkg::hamming_data_t d);
    logic [31:0] w;
    w = '0;
    w[`HAMMING_DATA_WIDTH-1:0] = d;
    w[`ECC_FLAG_BIT]           = flag;
    return w;
  endfunction

  function automatic logic [5:0] make_adr(input logic [1:0] region, input logic [3:0] idx);
    return {region, idx};
  endfunction

  function automatic void add_entry(input string name, input op_t op, input logic [5:0] adr,
                                    input logic [31:0] wdata, input logic [31:0] expected,
                                    input bit use_model);
    entry_t e;
    e.name      = name;
    e.op        = op;
    e.adr       = adr;
    e.wdata     = wdata;
    e.expected  = expected;
    e.use_model = use_model;
    test_table.push_back(e);
  endfunction

  function automatic void build_table();
    hamming_pkg::hamming_data_t  d;
    hamming_pkg::hamming_block_t blk;
    logic [31:0]                 rnd;
    logic [3:0]                  idx;
    add_entry("status_after_reset", OP_READ, make_adr(`ECC_REGION_STATUS, 4'd0), '0, '0, 0);
    // Clean round trips
    // Upper write bits are random and must be ignored
    for (int n = 0; n < 4; n++) begin
      rnd = $urandom();
      d   = rnd[`HAMMING_DATA_WIDTH-1:0];
      idx = 4'(n * 5);
      add_entry($sformatf("data_write_%0d", idx), OP_WRITE, make_adr(`ECC_REGION_DATA, idx),
                rnd, '0, 0);
      add_entry($sformatf("data_read_%0d", idx), OP_READ, make_adr(`ECC_REGION_DATA, idx),
                '0, data_word(1'b0, d), 0);
      add_entry($sformatf("raw_read_%0d", idx), OP_READ, make_adr(`ECC_REGION_RAW, idx),
                '0, {1'b0, model_encode(d)}, 0);
    end
    // One flipped bit per position over several indices
    for (int p = 1; p <= `HAMMING_BLOCK_WIDTH; p++) begin
      rnd      = $urandom();
      d        = rnd[`HAMMING_DATA_WIDTH-1:0];
      idx      = 4'(p);
      blk      = model_encode(d);
      blk[p-1] = ~blk[p-1];
      add_entry($sformatf("flip_write_%0d", p), OP_WRITE, make_adr(`ECC_REGION_RAW, idx),
                {1'b0, blk}, '0, 0);
      // Even positions take the answer from the model
      add_entry($sformatf("flip_read_%0d", p), OP_READ, make_adr(`ECC_REGION_DATA, idx),
                '0, data_word(1'b1, d), (p % 2) == 0);
    end
    add_entry("status_count", OP_READ, make_adr(`ECC_REGION_STATUS, 4'd0), '0,
              32'(`HAMMING_BLOCK_WIDTH), 0);
    add_entry("status_clear", OP_WRITE, make_adr(`ECC_REGION_STATUS, 4'd0), '0, '0, 0);
    add_entry("status_cleared", OP_READ, make_adr(`ECC_REGION_STATUS, 4'd0), '0, '0, 0);
    rnd = $urandom();
    add_entry("clean_write", OP_WRITE, make_adr(`ECC_REGION_DATA, 4'd3), rnd, '0, 0);
    add_entry("clean_read", OP_READ, make_adr(`ECC_REGION_DATA, 4'd3), '0,
              data_word(1'b0, rnd[`HAMMING_DATA_WIDTH-1:0]), 0);
    add_entry("status_after_clean", OP_READ, make_adr(`ECC_REGION_STATUS, 4'd0), '0, '0, 1);
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_rsp(input string name, input hamming_pkg::wb_rsp_t exp_rsp,
                             input hamming_pkg::wb_rsp_t act_rsp);
    if (act_rsp !== exp_rsp) begin
      $display("FAIL %s: expected ack=%b dat=%h, actual ack=%b dat=%h",
               name, exp_rsp.ack, exp_rsp.dat, act_rsp.ack, act_rsp.dat);
      fail_count++;
      abort_run();
    end
  endtask

  task automatic compare_block(input string name, input hamming_pkg::hamming_block_t exp_blk,
                               input hamming_pkg::hamming_block_t act_blk);
    if (act_blk !== exp_blk) begin
      $display("FAIL %s: expected block %h, actual block %h", name, exp_blk, act_blk);
      fail_count++;
      abort_run();
    end
  endtask

  task automatic compare_latency(input string name, input int exp_cycles, input int act_cycles);
    if (act_cycles != exp_cycles) begin
      $display("FAIL %s: expected ack latency %0d, actual ack latency %0d",
               name, exp_cycles, act_cycles);
      fail_count++;
      abort_run();
    end
  endtask

  // Classic single transfer
  // Ack is sampled at the edge and the request dropped on that same edge
  task automatic bus_transfer(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                              output hamming_pkg::wb_rsp_t rsp, output int ack_edges);
    hamming_pkg::wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    @(posedge clk);
    wb_req <= req;
    ack_edges = 0;
    do begin
      @(posedge clk);
      ack_edges++;
    end while (wb_rsp.ack !== 1'b1);
    rsp = wb_rsp;
    wb_req <= '0;
  endtask

  task automatic apply_entry(input entry_t e);
    hamming_pkg::wb_rsp_t             rsp;
    hamming_pkg::wb_rsp_t             exp_rsp;
    hamming_pkg::hamming_block_t      blk;
    logic [`HAMMING_PARITY_WIDTH-1:0] syn;
    logic [1:0]                       region;
    logic [3:0]                       idx;
    logic [31:0]                      model_value;
    int                               ack_edges;
    int                               exp_latency;
    region      = e.adr[5:4];
    idx         = e.adr[3:0];
    model_value = '0;
    bus_transfer(e.op == OP_WRITE, e.adr, e.wdata, rsp, ack_edges);
    // Writes and STATUS reads ack after one cycle
    // Store reads take one more for the registered read
    exp_latency = 1;
    if ((e.op == OP_READ) &&
        ((region == `ECC_REGION_DATA) || (region == `ECC_REGION_RAW))) begin
      exp_latency = 2;
    end
    // Ack is seen at the edge that closes its own cycle
    compare_latency(e.name, exp_latency, ack_edges - 1);
    if (e.op == OP_WRITE) begin
      case (region)
        `ECC_REGION_DATA:   shadow_mem[idx] = model_encode(e.wdata[`HAMMING_DATA_WIDTH-1:0]);
        `ECC_REGION_RAW:    shadow_mem[idx] = e.wdata[`HAMMING_BLOCK_WIDTH-1:0];
        `ECC_REGION_STATUS: model_count = 0;
        default:            model_value = '0;
      endcase
    end else begin
      case (region)
        `ECC_REGION_DATA: begin
          blk = shadow_mem[idx];
          syn = model_syndrome(blk);
          // Nonzero syndrome names the bad position
          if (syn != '0) begin
            blk[syn - 1] = ~blk[syn - 1];
            if (model_count < COUNT_MAX) begin
              model_count++;
            end
          end
          model_value = data_word(syn != '0, model_extract(blk));
        end
        `ECC_REGION_RAW:    model_value = {1'b0, shadow_mem[idx]};
        `ECC_REGION_STATUS: model_value = 32'(model_count);
        default:            model_value = '0;
      endcase
      exp_rsp.ack = 1'b1;
      exp_rsp.dat = e.use_model ? model_value : e.expected;
      if (region == `ECC_REGION_RAW) begin
        compare_block(e.name, exp_rsp.dat[`HAMMING_BLOCK_WIDTH-1:0],
                      rsp.dat[`HAMMING_BLOCK_WIDTH-1:0]);
      end
      compare_rsp(e.name, exp_rsp, rsp);
    end
  endtask

  // Budget grows with the table
  initial begin
    wait (table_ready);
    repeat (RESET_CYCLES + 2 + test_table.size() * CYCLES_PER_ENTRY) @(posedge clk);
    $display("Watchdog expired, the bus stopped acknowledging requests");
    abort_run();
  end

  initial begin
    rst    = 1'b1;
    wb_req = '0;
    void'($urandom(32'h3500));
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (wb_rsp.ack !== 1'b0) begin
      $display("Ack was not low after reset");
      fail_count++;
      abort_run();
    end
    foreach (test_table[n]) begin
      apply_entry(test_table[n]);
    end
    if (fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire
